/* src.f */
+incdir+bench
common/fetch_pkg.sv
rvc_expander/rvc_expander.sv
logic/fetch_aligner.sv
logic/fetch_unit.sv
bench/fetch_unit_tb.sv

/* Makefile */
# Verilator build and run of the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
EXE       ?= $(TOP)
LOG       ?= sim.log
PASS_TEXT ?= All tests passed!
VFLAGS    ?= --binary --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := bench/fetch_vectors.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/$(EXE)

$(BUILD_DIR)/$(EXE): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(EXE)

run: compile
	-$(BUILD_DIR)/$(EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qxF "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/fetch_vectors.svh */
// columns: address, read data, control, expected instruction, expected flags
// control is {valid, flush, stall, ls_valid, mmu_valid, mmu_fault}
// flags are {compressed, valid, stall request}
task automatic load_table();
    // no data, then no data under a load/store
    add_row(32'h100, 32'h0000_0000, 6'b000000, NOP_WORD, 3'b001);
    add_row(32'h100, 32'h0000_0000, 6'b000100, NOP_WORD, 3'b000);
    // aligned full words, mmu response variants
    add_row(32'h100, 32'h0050_0093, 6'b100000, 32'h0050_0093, 3'b010);
    add_row(32'h104, 32'h00A0_0513, 6'b100011, 32'h00A0_0513, 3'b010);
    add_row(32'h108, 32'h0000_0013, 6'b100010, 32'h0000_0013, 3'b010);
    // compressed set, low and high halves
    add_row(32'h10C, 32'hDEAD_028D, 6'b100000, itype_enc(12'd3, 5'd5, 5'd5, OP_IMM), 3'b110);
    add_row(32'h110, 32'h0000_0001, 6'b100000, NOP_WORD, 3'b110);
    add_row(32'h112, 32'h557D_1234, 6'b100000, itype_enc(12'hFFF, 5'd0, 5'd10, OP_IMM), 3'b110);
    add_row(32'h114, 32'h0000_6185, 6'b100000, lui_enc(20'h00001, 5'd3), 3'b110);
    add_row(32'h116, 32'h71FD_0000, 6'b100000, lui_enc(20'hFFFFF, 5'd3), 3'b110);
    add_row(32'h118, 32'h0000_8426, 6'b100000, rtype_enc(5'd9, 5'd0, 5'd8), 3'b110);
    add_row(32'h11A, 32'h9426_0000, 6'b100000, rtype_enc(5'd9, 5'd8, 5'd8), 3'b110);
    add_row(32'h11C, 32'h0000_8082, 6'b100000, itype_enc(12'd0, 5'd1, 5'd0, OP_JALR), 3'b110);
    add_row(32'h11E, 32'hBFFD_0000, 6'b100000, jal_enc(21'h1FFFFE), 3'b110);
    add_row(32'h120, 32'h0000_A801, 6'b100000, jal_enc(21'd16), 3'b110);
    add_row(32'h122, 32'hA005_0000, 6'b100000, jal_enc(21'd32), 3'b110);
    // unsupported encodings expand to zero
    add_row(32'h124, 32'h0000_4398, 6'b100000, 32'h0000_0000, 3'b110);
    add_row(32'h126, 32'h9002_0000, 6'b100000, 32'h0000_0000, 3'b110);
    // split full word joined from the next word
    add_row(32'h202, 32'h0093_5555, 6'b100000, NOP_WORD, 3'b001);
    add_row(32'h204, 32'hAAAA_0050, 6'b100000, 32'h0050_0093, 3'b010);
    // stall holds off the capture, word shown again
    add_row(32'h302, 32'h0513_0000, 6'b101000, NOP_WORD, 3'b001);
    // nothing held, so the next word stands alone
    add_row(32'h304, 32'h0000_8426, 6'b100000, rtype_enc(5'd9, 5'd0, 5'd8), 3'b110);
    add_row(32'h302, 32'h0513_0000, 6'b100000, NOP_WORD, 3'b001);
    add_row(32'h304, 32'h0000_00A0, 6'b100000, 32'h00A0_0513, 3'b010);
    // flush drops the held half
    add_row(32'h402, 32'h0093_0000, 6'b100000, NOP_WORD, 3'b001);
    add_row(32'h404, 32'h0000_0000, 6'b010000, NOP_WORD, 3'b001);
    add_row(32'h404, 32'h0000_8426, 6'b100000, rtype_enc(5'd9, 5'd0, 5'd8), 3'b110);
    // nonsequential word while holding, then the right one
    add_row(32'h502, 32'h0093_0000, 6'b100000, NOP_WORD, 3'b001);
    add_row(32'h600, 32'h0050_0093, 6'b100000, NOP_WORD, 3'b001);
    add_row(32'h504, 32'h0000_0050, 6'b100000, 32'h0050_0093, 3'b010);
    // load/store masks the stall request
    add_row(32'h702, 32'h0093_0000, 6'b100100, NOP_WORD, 3'b000);
    add_row(32'h704, 32'h0000_0050, 6'b100000, 32'h0050_0093, 3'b010);
    add_row(32'h708, 32'h0050_0093, 6'b100100, 32'h0050_0093, 3'b010);
    // fault without a valid response, then with one
    add_row(32'h70C, 32'h0000_0000, 6'b000001, NOP_WORD, 3'b001);
    add_row(32'h70C, 32'h0000_0000, 6'b000011, NOP_WORD, 3'b001);
endtask

/* bench/fetch_unit_tb.sv */
`timescale 1ns/1ps

module fetch_unit_tb import fetch_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int RAND_COUNT = 40;
    localparam logic [31:0] LCG_SEED = 32'd86945;

    // one table row, inputs first then expected results
    typedef struct packed {
        fetch_word_t addr;
        fetch_word_t data;
        logic [5:0]  ctl;
        fetch_word_t exp_inst;
        logic [2:0]  exp_flags;
    } vec_t;

    logic        clk;
    logic        rst;
    fetch_word_t inst_addr;
    fetch_word_t rdata;
    logic        rdata_valid;
    logic        flush;
    logic        stall_in;
    logic        ls_valid;
    logic        mmu_valid;
    logic        mmu_fault;
    fetch_word_t addr_out;
    fetch_word_t inst_data;
    logic        is_compressed;
    logic        inst_valid;
    logic        ram_stall;
    trap_bus_t   trap_bus;

    vec_t        vec_q[$];
    logic        table_loaded;
    logic [31:0] lcg_state;
    int          word_errs;
    int          flag_errs;
    int          trap_errs;

    fetch_unit i_fetch_unit (
        .clk                  (clk),
        .rst                  (rst),
        .inst_addr_i          (inst_addr),
        .if_rdata_i           (rdata),
        .if_rdata_valid_i     (rdata_valid),
        .if_flush_i           (flush),
        .if_stall_i           (stall_in),
        .ls_valid_i           (ls_valid),
        .mmu_resp_valid_i     (mmu_valid),
        .mmu_page_fault_i     (mmu_fault),
        .inst_addr_o          (addr_out),
        .inst_data_o          (inst_data),
        .is_compressed_o      (is_compressed),
        .inst_valid_o         (inst_valid),
        .ram_stall_valid_if_o (ram_stall),
        .trap_bus_o           (trap_bus)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // standard rv32i encodings for expected words
    function automatic fetch_word_t itype_enc(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [4:0] rd, input logic [6:0] opcode);
        return {imm, rs1, 3'b000, rd, opcode};
    endfunction

    function automatic fetch_word_t rtype_enc(input logic [4:0] rs2, input logic [4:0] rs1,
                                              input logic [4:0] rd);
        return {7'b0000000, rs2, rs1, 3'b000, rd, OP_OP};
    endfunction

    function automatic fetch_word_t lui_enc(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OP_LUI};
    endfunction

    // jal x0 with a signed byte offset
    function automatic fetch_word_t jal_enc(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, OP_JAL};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic void add_row(input fetch_word_t addr, input fetch_word_t data,
                                    input logic [5:0] ctl, input fetch_word_t exp_inst,
                                    input logic [2:0] exp_flags);
        vec_t row;
        row.addr = addr;
        row.data = data;
        row.ctl = ctl;
        row.exp_inst = exp_inst;
        row.exp_flags = exp_flags;
        vec_q.push_back(row);
    endfunction

    `include "fetch_vectors.svh"

    task automatic check_word(input string name, input fetch_word_t exp,
                              input fetch_word_t act);
        if (act !== exp) begin
            word_errs++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errs++;
            $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_trap(input trap_bus_t exp, input trap_bus_t act);
        if (act !== exp) begin
            trap_errs++;
            $display("mismatch at %0t: trap_bus_o expected %h, got %h", $time, exp, act);
        end
    endtask

    // drive just after the edge, sample just before the next one
    task automatic apply_row(input vec_t row);
        trap_bus_t exp_trap;
        @(posedge clk);
        #1;
        inst_addr = row.addr;
        rdata = row.data;
        {rdata_valid, flush, stall_in, ls_valid, mmu_valid, mmu_fault} = row.ctl;
        #(CLK_PERIOD - 2);
        // page fault only with a valid mmu response
        exp_trap = '0;
        if (row.ctl[1] && row.ctl[0]) begin
            exp_trap[TRAP_INST_PAGE_FAULT] = 1'b1;
        end
        check_word("inst_addr_o", row.addr, addr_out);
        check_word("inst_data_o", row.exp_inst, inst_data);
        check_bit("is_compressed_o", row.exp_flags[2], is_compressed);
        check_bit("inst_valid_o", row.exp_flags[1], inst_valid);
        check_bit("ram_stall_valid_if_o", row.exp_flags[0], ram_stall);
        check_trap(exp_trap, trap_bus);
    endtask

    initial begin : main
        vec_t        row;
        fetch_word_t rand_addr;
        fetch_word_t rand_word;
        rst = 1'b1;
        inst_addr = '0;
        rdata = '0;
        rdata_valid = 1'b0;
        flush = 1'b0;
        stall_in = 1'b0;
        ls_valid = 1'b0;
        mmu_valid = 1'b0;
        mmu_fault = 1'b0;
        word_errs = 0;
        flag_errs = 0;
        trap_errs = 0;
        lcg_state = LCG_SEED;
        table_loaded = 1'b0;
        load_table();
        table_loaded = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        // directed table
        for (int i = 0; i < vec_q.size(); i++) begin
            apply_row(vec_q[i]);
        end
        // random aligned full words pass through untouched
        for (int n = 0; n < RAND_COUNT; n++) begin
            rand_addr = lcg_next();
            rand_word = lcg_next();
            row.addr = {rand_addr[31:2], 2'b00};
            row.data = {rand_word[31:2], RVC_FULL_MARK};
            row.ctl = 6'b100000;
            row.exp_inst = row.data;
            row.exp_flags = 3'b010;
            apply_row(row);
        end
        $display("errors: word %0d, flag %0d, trap %0d, total %0d",
                 word_errs, flag_errs, trap_errs, word_errs + flag_errs + trap_errs);
        if (word_errs + flag_errs + trap_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // run limit scales with the number of rows
    initial begin : watchdog
        int limit;
        wait (table_loaded);
        limit = (vec_q.size() + RAND_COUNT + 10) * CLK_PERIOD;
        #(limit);
        $display("timeout: the run did not finish within %0d ns", limit);
        $display("Test failures found");
        $finish;
    end

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  fetch_word_t inst_addr_i,
    input  fetch_word_t if_rdata_i,
    input  logic        if_rdata_valid_i,
    input  logic        if_flush_i,
    input  logic        if_stall_i,
    input  logic        ls_valid_i,
    input  logic        mmu_resp_valid_i,
    input  logic        mmu_page_fault_i,
    output fetch_word_t inst_addr_o,
    output fetch_word_t inst_data_o,
    output logic        is_compressed_o,
    output logic        inst_valid_o,
    output logic        ram_stall_valid_if_o,
    output trap_bus_t   trap_bus_o
);

    // aligner results
    fetch_word_t sel_inst;
    logic        sel_compressed;
    logic        sel_valid;

    // expanded form of the selected low half
    fetch_word_t exp_inst;

    fetch_aligner i_fetch_aligner (
        .clk              (clk),
        .rst              (rst),
        .inst_addr_i      (inst_addr_i),
        .if_rdata_i       (if_rdata_i),
        .if_rdata_valid_i (if_rdata_valid_i),
        .if_flush_i       (if_flush_i),
        .if_stall_i       (if_stall_i),
        .ls_valid_i       (ls_valid_i),
        .sel_inst_o       (sel_inst),
        .sel_compressed_o (sel_compressed),
        .sel_valid_o      (sel_valid),
        .stall_o          (ram_stall_valid_if_o)
    );

    rvc_expander i_rvc_expander (
        .c_inst_i (sel_inst[15:0]),
        .inst_o   (exp_inst)
    );

    // address passes straight to if/id
    assign inst_addr_o = inst_addr_i;

    // sel_inst is already nop when nothing is valid
    assign inst_data_o = sel_compressed ? exp_inst : sel_inst;
    assign is_compressed_o = sel_compressed;
    assign inst_valid_o = sel_valid;

    // page fault from the mmu response is the only live trap source
    always_comb begin
        trap_bus_o = '0;
        trap_bus_o[TRAP_INST_ADDR_MISALIGNED] = 1'b0;
        trap_bus_o[TRAP_INST_ACCESS_FAULT] = 1'b0;
        trap_bus_o[TRAP_INST_PAGE_FAULT] = mmu_resp_valid_i && mmu_page_fault_i;
    end

endmodule

/* logic/fetch_aligner.sv */
`timescale 1ns/1ps

module fetch_aligner import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  fetch_word_t inst_addr_i,
    input  fetch_word_t if_rdata_i,
    input  logic        if_rdata_valid_i,
    input  logic        if_flush_i,
    input  logic        if_stall_i,
    input  logic        ls_valid_i,
    output fetch_word_t sel_inst_o,
    output logic        sel_compressed_o,
    output logic        sel_valid_o,
    output logic        stall_o
);

    // halfword at the fetch address
    half_t cur_half;
    logic  cur_full;

    // held first half of a split instruction
    half_t            held_half;
    logic [XLEN-3:0]  held_idx;
    logic             held_vld;

    logic next_seq;
    logic split_start;
    logic capture;

    // address bit 1 picks the half
    assign cur_half = inst_addr_i[1] ? if_rdata_i[31:16] : if_rdata_i[15:0];
    assign cur_full = (cur_half[1:0] == RVC_FULL_MARK);

    // second word of a split instruction is the next word index
    assign next_seq = held_vld && if_rdata_valid_i &&
                      (inst_addr_i[XLEN-1:2] == held_idx + (XLEN-2)'(1));

    // full instruction starting in the upper half
    assign split_start = if_rdata_valid_i && cur_full && inst_addr_i[1] && !held_vld;

    // back-pressure holds off the capture, word is re-presented
    assign capture = split_start && !if_stall_i;

    // held flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held_vld <= 1'b0;
        end else if (if_flush_i) begin
            held_vld <= 1'b0;
        end else if (capture) begin
            held_vld <= 1'b1;
        end else if (next_seq) begin
            // joined instruction offered this cycle
            held_vld <= 1'b0;
        end
    end

    // held payload, only meaningful while held_vld is set
    always_ff @(posedge clk) begin
        if (capture) begin
            held_half <= cur_half;
            held_idx <= inst_addr_i[XLEN-1:2];
        end
    end

    // instruction choice
    always_comb begin
        sel_inst_o = NOP_WORD;
        sel_compressed_o = 1'b0;
        sel_valid_o = 1'b0;
        if (held_vld) begin
            // low half of the new word completes the instruction
            if (next_seq) begin
                sel_inst_o = {if_rdata_i[15:0], held_half};
                sel_valid_o = 1'b1;
            end
        end else if (if_rdata_valid_i) begin
            if (!cur_full) begin
                // compressed, upper bits zero until expanded
                sel_inst_o = {16'h0000, cur_half};
                sel_compressed_o = 1'b1;
                sel_valid_o = 1'b1;
            end else if (!inst_addr_i[1]) begin
                // aligned full word
                sel_inst_o = if_rdata_i;
                sel_valid_o = 1'b1;
            end
        end
    end

    // stall when nothing to offer or waiting for a second half
    // a load/store in progress owns the memory port
    assign stall_o = (!sel_valid_o || split_start) && !ls_valid_i;

    // a split start never comes with a valid instruction
    a_no_valid_on_split: assert property (
        @(posedge clk) disable iff (rst)
        !(sel_valid_o && split_start)
    ) else $error("aligner offered an instruction on a split start");

    // flush drops the held half by the next cycle
    a_flush_clears_held: assert property (
        @(posedge clk) disable iff (rst)
        if_flush_i |=> !held_vld
    ) else $error("held half survived a flush");

endmodule

/* rvc_expander/rvc_expander.sv */
`timescale 1ns/1ps

module rvc_expander import fetch_pkg::*; (
    input  half_t       c_inst_i,
    output fetch_word_t inst_o
);

    // same halfword, decoded through the view the quadrant selects
    rvc_half_u rvc;

    // sign-extended ci immediate for addi
    logic [11:0] ci_imm12;

    // sign-extended ci immediate for lui upper bits
    logic [19:0] lui_imm20;

    // c.j offset bits 11..1 put back in order
    logic [11:1] j_off;

    assign rvc = c_inst_i;

    assign ci_imm12 = {{7{rvc.ci.imm_hi}}, rvc.ci.imm_lo};
    assign lui_imm20 = {{15{rvc.ci.imm_hi}}, rvc.ci.imm_lo};

    // cj target field holds offset[11|4|9:8|10|6|7|3:1|5]
    assign j_off[11] = rvc.cj.target[10];
    assign j_off[10] = rvc.cj.target[6];
    assign j_off[9:8] = rvc.cj.target[8:7];
    assign j_off[7] = rvc.cj.target[4];
    assign j_off[6] = rvc.cj.target[5];
    assign j_off[5] = rvc.cj.target[0];
    assign j_off[4] = rvc.cj.target[9];
    assign j_off[3:1] = rvc.cj.target[3:1];

    always_comb begin
        // anything not handled below stays illegal
        inst_o = '0;
        case (rvc.ci.op)
            RVC_Q1: begin
                case (rvc.ci.funct3)
                    // addi rd, rd, imm
                    // rd = 0 with imm = 0 is c.nop
                    RVC_F3_ADDI: begin
                        inst_o = {ci_imm12, rvc.ci.rd, 3'b000, rvc.ci.rd, OP_IMM};
                    end
                    // addi rd, x0, imm
                    RVC_F3_LI: begin
                        inst_o = {ci_imm12, 5'd0, 3'b000, rvc.ci.rd, OP_IMM};
                    end
                    // lui rd, imm
                    // rd = 2 is c.addi16sp, zero imm is reserved
                    RVC_F3_LUI: begin
                        if (rvc.ci.rd != 5'd0 && rvc.ci.rd != 5'd2 &&
                            {rvc.ci.imm_hi, rvc.ci.imm_lo} != 6'd0) begin
                            inst_o = {lui_imm20, rvc.ci.rd, OP_LUI};
                        end
                    end
                    // jal x0, offset
                    RVC_F3_J: begin
                        inst_o = {j_off[11], j_off[10:1], j_off[11],
                                  {8{j_off[11]}}, 5'd0, OP_JAL};
                    end
                    default: begin
                        inst_o = '0;
                    end
                endcase
            end
            RVC_Q2: begin
                case (rvc.cr.funct4)
                    RVC_F4_JR_MV: begin
                        if (rvc.cr.rs2 == 5'd0) begin
                            // jalr x0, 0(rs1)
                            // rs1 = 0 is reserved
                            if (rvc.cr.rd_rs1 != 5'd0) begin
                                inst_o = {12'h000, rvc.cr.rd_rs1, 3'b000, 5'd0, OP_JALR};
                            end
                        end else begin
                            // add rd, x0, rs2
                            inst_o = {7'b0000000, rvc.cr.rs2, 5'd0, 3'b000,
                                      rvc.cr.rd_rs1, OP_OP};
                        end
                    end
                    RVC_F4_ADD: begin
                        // add rd, rd, rs2
                        // rs2 = 0 is c.jalr or c.ebreak, not supported
                        if (rvc.cr.rs2 != 5'd0) begin
                            inst_o = {7'b0000000, rvc.cr.rs2, rvc.cr.rd_rs1, 3'b000,
                                      rvc.cr.rd_rs1, OP_OP};
                        end
                    end
                    default: begin
                        inst_o = '0;
                    end
                endcase
            end
            default: begin
                inst_o = '0;
            end
        endcase
    end

    // expanded word is illegal zero or a full 32-bit encoding
    always_comb begin
        a_full_or_zero: assert (inst_o == '0 || inst_o[1:0] == RVC_FULL_MARK)
            else $error("expander produced a non 32-bit encoding");
    end

endmodule

/* common/fetch_pkg.sv */
package fetch_pkg;

    // base widths of the fetch path
    localparam int XLEN = 32;
    localparam int HLEN = 16;

    // fetch word, used for address, raw data and final instruction
    typedef logic [XLEN-1:0] fetch_word_t;

    // one halfword of a fetch word
    typedef logic [HLEN-1:0] half_t;

    // trap vector layout
    localparam int TRAP_LEN = 16;
    localparam int TRAP_INST_ADDR_MISALIGNED = 0;
    localparam int TRAP_INST_ACCESS_FAULT = 1;
    localparam int TRAP_INST_PAGE_FAULT = 12;

    typedef logic [TRAP_LEN-1:0] trap_bus_t;

    // addi x0, x0, 0
    localparam fetch_word_t NOP_WORD = 32'h0000_0013;

    // low two bits of a full 32-bit instruction
    localparam logic [1:0] RVC_FULL_MARK = 2'b11;

    // rv32i major opcodes produced by the expander
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_OP = 7'b0110011;
    localparam logic [6:0] OP_JAL = 7'b1101111;
    localparam logic [6:0] OP_JALR = 7'b1100111;

    // compressed quadrants in use
    localparam logic [1:0] RVC_Q1 = 2'b01;
    localparam logic [1:0] RVC_Q2 = 2'b10;

    // quadrant 1 funct3 codes
    localparam logic [2:0] RVC_F3_ADDI = 3'b000;
    localparam logic [2:0] RVC_F3_LI = 3'b010;
    localparam logic [2:0] RVC_F3_LUI = 3'b011;
    localparam logic [2:0] RVC_F3_J = 3'b101;

    // quadrant 2 funct4 codes
    // 1000 holds c.jr and c.mv, split on rs2
    // 1001 holds c.add, c.jalr and c.ebreak
    localparam logic [3:0] RVC_F4_JR_MV = 4'b1000;
    localparam logic [3:0] RVC_F4_ADD = 4'b1001;

    // one compressed halfword seen through its format views
    typedef union packed {
        // immediate format, c.addi / c.li / c.lui
        struct packed {
            logic [2:0] funct3;
            logic       imm_hi;
            logic [4:0] rd;
            logic [4:0] imm_lo;
            logic [1:0] op;
        } ci;
        // register format, c.mv / c.add / c.jr
        struct packed {
            logic [3:0] funct4;
            logic [4:0] rd_rs1;
            logic [4:0] rs2;
            logic [1:0] op;
        } cr;
        // jump format, c.j
        // target bits arrive scrambled
        struct packed {
            logic [2:0]  funct3;
            logic [10:0] target;
            logic [1:0]  op;
        } cj;
    } rvc_half_u;

endpackage
